// File: source/tag_pkg.sv
package tag_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  localparam int CLIENT_W  = 3;
  localparam int LEN_W     = 4;
  localparam int PAYLOAD_W = 8;

  // Start bit plus client and len fields
  localparam int HDR_W   = 1 + CLIENT_W + LEN_W;
  localparam int FRAME_W = HDR_W + PAYLOAD_W;

  localparam int TRACE_DEPTH  = 32;
  localparam int TRACE_ADDR_W = 5;

  typedef logic [CLIENT_W-1:0]  client_id_t;
  typedef logic [LEN_W-1:0]     len_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;

  ////////////////////
  // Trace and packet words
  ////////////////////

  typedef enum logic [1:0] {
    TAG_OP_SEND = 2'd0,
    TAG_OP_WAIT = 2'd1,
    TAG_OP_DONE = 2'd2,
    TAG_OP_NOP  = 2'd3
  } tag_op_t;

  // One ROM word, 17 bits
  typedef struct packed {
    tag_op_t    op;
    client_id_t client;
    len_t       len;
    payload_t   payload;
  } tag_trace_entry_t;

  // One FIFO word, 16 bits
  typedef struct packed {
    logic       last;
    client_id_t client;
    len_t       len;
    payload_t   payload;
  } tag_packet_t;

endpackage

// File: source/tag_trace_rom.sv
`timescale 1ns/1ns

module tag_trace_rom (
  input  logic [tag_pkg::TRACE_ADDR_W-1:0] addr_i,
  output tag_pkg::tag_trace_entry_t        data_o
);

  localparam int ENTRY_W = $bits(tag_pkg::tag_trace_entry_t);

  logic [ENTRY_W-1:0] rom [tag_pkg::TRACE_DEPTH];

  // Trace image, one hex word per line
  initial
  begin
    $readmemh("tag_trace.hex", rom);
  end

  assign data_o = tag_pkg::tag_trace_entry_t'(rom[addr_i]);

endmodule

// File: source/tag_trace_replay.sv
`timescale 1ns/1ns

module tag_trace_replay (
  input  logic                              tag_clk_i,
  input  logic                              rst_n_i,
  input  logic                              en_i,
  output logic [tag_pkg::TRACE_ADDR_W-1:0]  rom_addr_o,
  input  tag_pkg::tag_trace_entry_t         rom_data_i,
  input  logic                              inj_valid_i,
  input  tag_pkg::tag_packet_t              inj_pkt_i,
  output logic                              inj_ready_o,
  output logic                              push_valid_o,
  output tag_pkg::tag_packet_t              push_pkt_o,
  input  logic                              push_ready_i
);

  typedef enum logic [1:0] {
    ST_RUN,
    ST_WAIT,
    ST_HOST
  } state_e;

  state_e                           state_r;
  logic [tag_pkg::TRACE_ADDR_W-1:0] addr_r;
  tag_pkg::payload_t                wait_cnt_r;
  logic                             hold_r;
  logic                             go;
  logic                             addr_adv;

  // A stalled push keeps going even if en_i drops
  assign go         = en_i | hold_r;
  assign rom_addr_o = addr_r;

  always_comb
  begin
    push_valid_o = 1'b0;
    push_pkt_o   = '0;
    inj_ready_o  = 1'b0;
    addr_adv     = 1'b0;
    case (state_r)
      ST_RUN:
      begin
        if (go)
        begin
          push_pkt_o.client  = rom_data_i.client;
          push_pkt_o.len     = rom_data_i.len;
          push_pkt_o.payload = rom_data_i.payload;
          case (rom_data_i.op)
            tag_pkg::TAG_OP_SEND:
            begin
              push_valid_o = 1'b1;
              addr_adv     = push_ready_i;
            end
            tag_pkg::TAG_OP_DONE:
            begin
              push_valid_o    = 1'b1;
              push_pkt_o.last = 1'b1;
            end
            default:
            begin
              addr_adv = 1'b1;
            end
          endcase
        end
      end
      ST_HOST:
      begin
        push_valid_o = inj_valid_i;
        push_pkt_o   = inj_pkt_i;
        inj_ready_o  = push_ready_i;
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge tag_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= ST_RUN;
      addr_r     <= '0;
      wait_cnt_r <= '0;
      hold_r     <= 1'b0;
    end
    else
    begin
      hold_r <= (state_r == ST_RUN) && push_valid_o && !push_ready_i;
      if (addr_adv)
        addr_r <= addr_r + 1'b1;
      case (state_r)
        ST_RUN:
        begin
          if (go && rom_data_i.op == tag_pkg::TAG_OP_WAIT && rom_data_i.payload != '0)
          begin
            state_r    <= ST_WAIT;
            wait_cnt_r <= rom_data_i.payload;
          end
          if (go && rom_data_i.op == tag_pkg::TAG_OP_DONE && push_ready_i)
            state_r <= ST_HOST;
        end
        ST_WAIT:
        begin
          wait_cnt_r <= wait_cnt_r - 1'b1;
          if (wait_cnt_r == 8'd1)
            state_r <= ST_RUN;
        end
        default:
        begin
        end
      endcase
    end
  end

  // Trace must reach DONE before running off the ROM
  a_addr_in_range: assert property (@(posedge tag_clk_i) disable iff (!rst_n_i)
    addr_adv |-> addr_r != tag_pkg::TRACE_ADDR_W'(tag_pkg::TRACE_DEPTH - 1));

endmodule

// File: source/tag_packet_fifo.sv
`timescale 1ns/1ns

module tag_packet_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                 tag_clk_i,
  input  logic                 rst_n_i,
  input  logic                 push_valid_i,
  input  tag_pkg::tag_packet_t push_pkt_i,
  output logic                 push_ready_o,
  output logic                 pop_valid_o,
  output tag_pkg::tag_packet_t pop_pkt_o,
  input  logic                 pop_yumi_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  tag_pkg::tag_packet_t mem_r [DEPTH];
  logic [PTR_W-1:0]     rd_ptr_r;
  logic [PTR_W-1:0]     wr_ptr_r;
  logic [CNT_W-1:0]     count_r;
  logic                 do_push;

  assign push_ready_o = (count_r != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_r != '0);
  assign pop_pkt_o    = mem_r[rd_ptr_r];
  assign do_push      = push_valid_i & push_ready_o;

  always_ff @(posedge tag_clk_i)
  begin
    if (do_push)
      mem_r[wr_ptr_r] <= push_pkt_i;
  end

  always_ff @(posedge tag_clk_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop_yumi_i)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_r + CNT_W'(do_push) - CNT_W'(pop_yumi_i);
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // A push refused while full stays pending
  a_no_push_full: assert property (@(posedge tag_clk_i) disable iff (!rst_n_i)
    push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_pkt_i));

  a_yumi_valid: assert property (@(posedge tag_clk_i) disable iff (!rst_n_i)
    pop_yumi_i |-> pop_valid_o);

endmodule

// File: source/tag_master_serializer.sv
`timescale 1ns/1ns

module tag_master_serializer (
  input  logic                 tag_clk_i,
  input  logic                 rst_n_i,
  input  logic                 pop_valid_i,
  input  tag_pkg::tag_packet_t pop_pkt_i,
  output logic                 pop_yumi_o,
  output logic                 tag_data_o,
  output logic                 tag_en_o,
  output logic                 done_o
);

  localparam int CNT_W = $clog2(tag_pkg::FRAME_W + 1);

  typedef enum logic {
    ST_IDLE,
    ST_SHIFT
  } state_e;

  state_e                      state_r;
  logic [tag_pkg::FRAME_W-1:0] shift_r;
  logic [CNT_W-1:0]            bit_cnt_r;
  logic                        done_r;
  logic                        free;

  // Idle, or on the final bit of the current frame
  assign free       = (state_r == ST_IDLE) || (bit_cnt_r == CNT_W'(1));
  assign pop_yumi_o = pop_valid_i & free;

  assign tag_en_o   = (state_r == ST_SHIFT);
  assign tag_data_o = tag_en_o & shift_r[0];
  assign done_o     = done_r;

  // Start bit sits in bit 0, fields follow LSB first
  always_ff @(posedge tag_clk_i)
  begin
    if (pop_yumi_o)
      shift_r <= {pop_pkt_i.payload, pop_pkt_i.len, pop_pkt_i.client, 1'b1};
    else
      shift_r <= shift_r >> 1;
  end

  always_ff @(posedge tag_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= ST_IDLE;
      bit_cnt_r <= '0;
      done_r    <= 1'b0;
    end
    else
    begin
      if (pop_yumi_o)
      begin
        if (pop_pkt_i.last)
        begin
          // End marker sends nothing
          done_r    <= 1'b1;
          state_r   <= ST_IDLE;
          bit_cnt_r <= '0;
        end
        else
        begin
          state_r   <= ST_SHIFT;
          bit_cnt_r <= CNT_W'(tag_pkg::HDR_W) + CNT_W'(pop_pkt_i.len);
        end
      end
      else if (state_r == ST_SHIFT)
      begin
        bit_cnt_r <= bit_cnt_r - 1'b1;
        if (bit_cnt_r == CNT_W'(1))
          state_r <= ST_IDLE;
      end
    end
  end

  // Enable only while bits of the shift register remain to be sent
  a_en_in_frame: assert property (@(posedge tag_clk_i) disable iff (!rst_n_i)
    tag_en_o |-> bit_cnt_r != '0 && bit_cnt_r <= CNT_W'(tag_pkg::FRAME_W));

endmodule

// File: source/tag_master.sv
`timescale 1ns/1ns

module tag_master #(
  parameter int NUM_CLIENTS = 8
) (
  input  logic                                tag_clk_i,
  input  logic                                rst_n_i,
  input  logic                                tag_data_i,
  input  logic                                tag_en_i,
  output tag_pkg::payload_t [NUM_CLIENTS-1:0] clients_r_o
);

  localparam int FIELD_W = tag_pkg::CLIENT_W + tag_pkg::LEN_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD
  } state_e;

  state_e              state_r;
  logic [2:0]          cnt_r;
  logic [FIELD_W-1:0]  hdr_r;
  logic [FIELD_W-1:0]  hdr_next;
  tag_pkg::client_id_t client_r;
  tag_pkg::len_t       len_r;
  tag_pkg::payload_t   pay_r;
  tag_pkg::payload_t   wr_data;
  logic                last_bit;
  logic                wr_en;

  // Fields arrive LSB first, so shift in from the top
  assign hdr_next = {tag_data_i, hdr_r[FIELD_W-1:1]};

  assign last_bit = ({1'b0, cnt_r} == len_r - 1'b1);
  assign wr_data  = pay_r | (tag_pkg::payload_t'(tag_data_i) << cnt_r);
  assign wr_en    = (state_r == ST_PAYLOAD) && tag_en_i && last_bit
                    && (int'(client_r) < NUM_CLIENTS);

  always_ff @(posedge tag_clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r  <= ST_IDLE;
      cnt_r    <= '0;
      hdr_r    <= '0;
      client_r <= '0;
      len_r    <= '0;
      pay_r    <= '0;
    end
    else if (!tag_en_i)
      state_r <= ST_IDLE;
    else
    begin
      case (state_r)
        ST_IDLE:
        begin
          if (tag_data_i)
          begin
            state_r <= ST_HEADER;
            cnt_r   <= '0;
          end
        end
        ST_HEADER:
        begin
          hdr_r <= hdr_next;
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == 3'(FIELD_W - 1))
          begin
            state_r  <= ST_PAYLOAD;
            client_r <= hdr_next[tag_pkg::CLIENT_W-1:0];
            len_r    <= hdr_next[FIELD_W-1:tag_pkg::CLIENT_W];
            cnt_r    <= '0;
            pay_r    <= '0;
          end
        end
        ST_PAYLOAD:
        begin
          // Bits above len stay zero
          pay_r <= wr_data;
          cnt_r <= cnt_r + 1'b1;
          if (last_bit)
            state_r <= ST_IDLE;
        end
        default:
          state_r <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge tag_clk_i)
  begin
    if (!rst_n_i)
      clients_r_o <= '0;
    else if (wr_en)
      clients_r_o[client_r] <= wr_data;
  end

  a_len_range: assert property (@(posedge tag_clk_i) disable iff (!rst_n_i)
    state_r == ST_HEADER && tag_en_i && cnt_r == 3'(FIELD_W - 1)
    |=> len_r >= 4'd1 && len_r <= 4'd8);

endmodule

// File: source/tag_gateway.sv
`timescale 1ns/1ns

module tag_gateway #(
  parameter int FIFO_DEPTH  = 4,
  parameter int NUM_CLIENTS = 8
) (
  input  logic                                tag_clk_i,
  input  logic                                rst_n_i,
  input  logic                                en_i,
  input  logic                                inj_valid_i,
  input  tag_pkg::tag_packet_t                inj_pkt_i,
  output logic                                inj_ready_o,
  output logic                                tag_data_o,
  output logic                                tag_en_o,
  output logic                                done_o,
  output tag_pkg::payload_t [NUM_CLIENTS-1:0] clients_r_o
);

  logic [tag_pkg::TRACE_ADDR_W-1:0] rom_addr;
  tag_pkg::tag_trace_entry_t        rom_data;

  logic                 push_valid;
  tag_pkg::tag_packet_t push_pkt;
  logic                 push_ready;
  logic                 pop_valid;
  tag_pkg::tag_packet_t pop_pkt;
  logic                 pop_yumi;

  ////////////////////
  // Trace source
  ////////////////////

  tag_trace_rom i_tag_trace_rom (
    .addr_i ( rom_addr ),
    .data_o ( rom_data )
  );

  tag_trace_replay i_tag_trace_replay (
    .tag_clk_i    ( tag_clk_i   ),
    .rst_n_i      ( rst_n_i     ),
    .en_i         ( en_i        ),
    .rom_addr_o   ( rom_addr    ),
    .rom_data_i   ( rom_data    ),
    .inj_valid_i  ( inj_valid_i ),
    .inj_pkt_i    ( inj_pkt_i   ),
    .inj_ready_o  ( inj_ready_o ),
    .push_valid_o ( push_valid  ),
    .push_pkt_o   ( push_pkt    ),
    .push_ready_i ( push_ready  )
  );

  tag_packet_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) i_tag_packet_fifo (
    .tag_clk_i    ( tag_clk_i  ),
    .rst_n_i      ( rst_n_i    ),
    .push_valid_i ( push_valid ),
    .push_pkt_i   ( push_pkt   ),
    .push_ready_o ( push_ready ),
    .pop_valid_o  ( pop_valid  ),
    .pop_pkt_o    ( pop_pkt    ),
    .pop_yumi_i   ( pop_yumi   )
  );

  ////////////////////
  // Tag line
  ////////////////////

  tag_master_serializer i_tag_master_serializer (
    .tag_clk_i   ( tag_clk_i  ),
    .rst_n_i     ( rst_n_i    ),
    .pop_valid_i ( pop_valid  ),
    .pop_pkt_i   ( pop_pkt    ),
    .pop_yumi_o  ( pop_yumi   ),
    .tag_data_o  ( tag_data_o ),
    .tag_en_o    ( tag_en_o   ),
    .done_o      ( done_o     )
  );

  tag_master #(
    .NUM_CLIENTS ( NUM_CLIENTS )
  ) i_tag_master (
    .tag_clk_i   ( tag_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .tag_data_i  ( tag_data_o  ),
    .tag_en_i    ( tag_en_o    ),
    .clients_r_o ( clients_r_o )
  );

endmodule

// File: tests/tb_tag_gateway.sv
`timescale 1ns/1ns

module tb_tag_gateway;

  localparam int FIFO_DEPTH  = 4;
  localparam int NUM_CLIENTS = 8;
  localparam int CLK_PERIOD  = 40;
  localparam int HOST_PKTS   = 12;
  // Worst case per trace word, host frames, margin
  localparam int LIMIT_CYCLES = tag_pkg::TRACE_DEPTH * (16 + 256) + 64 * 16 + 200;

  logic                                tag_clk = 1'b0;
  logic                                rst_n;
  logic                                en;
  logic                                inj_valid;
  tag_pkg::tag_packet_t                inj_pkt;
  logic                                inj_ready;
  logic                                tag_data;
  logic                                tag_en;
  logic                                done;
  tag_pkg::payload_t [NUM_CLIENTS-1:0] clients;

  logic [15:0]                         lfsr_r;
  tag_pkg::tag_packet_t                exp_q [$];
  tag_pkg::payload_t [NUM_CLIENTS-1:0] trace_regs;
  tag_pkg::payload_t [NUM_CLIENTS-1:0] host_regs;
  int                                  trace_sends;
  int                                  phase;
  int                                  errs [1:6];
  logic                                host_check;

  // Frame decoder state
  logic [3:0]           fk;
  logic [15:0]          fbits;
  logic [15:0]          fnext;
  logic [15:0]          got;
  logic                 fvalid;
  tag_pkg::tag_packet_t exp_pkt;
  logic                 exp_have;
  int                   exp_idx;

  logic rst_prev   = 1'b1;
  logic accepted   = 1'b0;
  logic stall_seen = 1'b0;

  tag_gateway #(
    .FIFO_DEPTH  ( FIFO_DEPTH  ),
    .NUM_CLIENTS ( NUM_CLIENTS )
  ) i_tag_gateway (
    .tag_clk_i   ( tag_clk   ),
    .rst_n_i     ( rst_n     ),
    .en_i        ( en        ),
    .inj_valid_i ( inj_valid ),
    .inj_pkt_i   ( inj_pkt   ),
    .inj_ready_o ( inj_ready ),
    .tag_data_o  ( tag_data  ),
    .tag_en_o    ( tag_en    ),
    .done_o      ( done      ),
    .clients_r_o ( clients   )
  );

  always #(CLK_PERIOD / 2) tag_clk = ~tag_clk;

  ////////////////////
  // Model helpers
  ////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      v = (v << 1) | int'(lfsr_r[0]);
    end
    return v;
  endfunction

  function automatic tag_pkg::payload_t masked(input tag_pkg::payload_t p,
                                               input tag_pkg::len_t l);
    logic [8:0] m;
    m = (9'd1 << l) - 9'd1;
    return p & m[7:0];
  endfunction

  task automatic build_model();
    logic [16:0]               words [tag_pkg::TRACE_DEPTH];
    tag_pkg::tag_trace_entry_t ent;
    tag_pkg::tag_packet_t      p;
    bit                        stop;
    stop       = 1'b0;
    trace_regs = '0;
    $readmemh("tag_trace.hex", words);
    for (int i = 0; i < tag_pkg::TRACE_DEPTH && !stop; i++)
    begin
      ent = tag_pkg::tag_trace_entry_t'(words[i]);
      if (ent.op == tag_pkg::TAG_OP_SEND)
      begin
        p.last    = 1'b0;
        p.client  = ent.client;
        p.len     = ent.len;
        p.payload = ent.payload;
        exp_q.push_back(p);
        trace_regs[ent.client] = masked(ent.payload, ent.len);
      end
      else if (ent.op == tag_pkg::TAG_OP_DONE)
        stop = 1'b1;
    end
    trace_sends = exp_q.size();
    host_regs   = trace_regs;
  endtask

  // Tests 4 and 5 own every failure seen while they run
  task automatic note_fail(input int which);
    if (which == 1 || which == 6 || phase < 4)
      errs[which]++;
    else
      errs[phase]++;
  endtask

  task automatic report_value(input int which, input string name,
                              input logic [63:0] got_v, input logic [63:0] exp_v);
    $display("[FAIL] %s got %h expected %h at %0t", name, got_v, exp_v, $time);
    note_fail(which);
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  assign fnext = fbits | (16'(tag_data) << fk);

  always @(posedge tag_clk)
  begin
    if (!rst_n)
    begin
      fk       <= '0;
      fbits    <= '0;
      fvalid   <= 1'b0;
      exp_have <= 1'b0;
      exp_idx  <= 0;
    end
    else
    begin
      fvalid <= 1'b0;
      if (tag_en)
      begin
        if (fk >= 4'd8 && (fk == 4'd7 + fnext[7:4] || fk == 4'd15))
        begin
          got      <= fnext;
          fvalid   <= 1'b1;
          fk       <= '0;
          fbits    <= '0;
          exp_have <= (exp_idx < exp_q.size());
          if (exp_idx < exp_q.size())
            exp_pkt <= exp_q[exp_idx];
          exp_idx  <= exp_idx + 1;
        end
        else
        begin
          fbits <= fnext;
          fk    <= fk + 4'd1;
        end
      end
    end
  end

  always @(posedge tag_clk)
  begin
    rst_prev <= rst_n;
    accepted <= inj_valid && inj_ready;
    if (inj_valid && !inj_ready)
      stall_seen <= 1'b1;
  end

  ////////////////////
  // Checks
  ////////////////////

  a_rst_en: assert property (@(posedge tag_clk) !rst_prev |-> tag_en == 1'b0)
    else report_value(1, "tag_en_o", 64'($sampled(tag_en)), 64'(0));
  a_rst_done: assert property (@(posedge tag_clk) !rst_prev |-> done == 1'b0)
    else report_value(1, "done_o", 64'($sampled(done)), 64'(0));
  a_rst_ready: assert property (@(posedge tag_clk) !rst_prev |-> inj_ready == 1'b0)
    else report_value(1, "inj_ready_o", 64'($sampled(inj_ready)), 64'(0));
  a_rst_clients: assert property (@(posedge tag_clk) !rst_prev |-> clients == '0)
    else report_value(1, "clients_r_o", 64'($sampled(clients)), 64'(0));

  a_start: assert property (@(posedge tag_clk) disable iff (!rst_n) fvalid |-> got[0])
    else report_value(2, "tag_data_o start bit", 64'($sampled(got[0])), 64'(1));
  a_client: assert property (@(posedge tag_clk) disable iff (!rst_n)
    fvalid && exp_have |-> got[3:1] == exp_pkt.client)
    else report_value(2, "tag_data_o client", 64'($sampled(got[3:1])), 64'(exp_pkt.client));
  a_len: assert property (@(posedge tag_clk) disable iff (!rst_n)
    fvalid && exp_have |-> got[7:4] == exp_pkt.len)
    else report_value(2, "tag_data_o len", 64'($sampled(got[7:4])), 64'(exp_pkt.len));
  a_payload: assert property (@(posedge tag_clk) disable iff (!rst_n)
    fvalid && exp_have |-> got[15:8] == masked(exp_pkt.payload, exp_pkt.len))
    else report_value(2, "tag_data_o payload", 64'($sampled(got[15:8])),
                      64'(masked(exp_pkt.payload, exp_pkt.len)));
  a_extra: assert property (@(posedge tag_clk) disable iff (!rst_n) fvalid |-> exp_have)
  else
  begin
    $display("a frame arrived on the tag line with no packet left to expect");
    note_fail(2);
  end
  a_cut: assert property (@(posedge tag_clk) disable iff (!rst_n) fk != 4'd0 |-> tag_en)
  else
  begin
    $display("tag_en_o dropped in the middle of a frame at %0t", $time);
    note_fail(2);
  end
  a_count: assert property (@(posedge tag_clk) disable iff (!rst_n)
    $rose(done) |-> exp_idx == trace_sends)
    else report_value(2, "frame count at done_o", 64'($sampled(exp_idx)), 64'(trace_sends));

  a_regs_done: assert property (@(posedge tag_clk) disable iff (!rst_n)
    $rose(done) |-> clients == trace_regs)
    else report_value(3, "clients_r_o", 64'($sampled(clients)), 64'(trace_regs));

  // A frame start needs a packet popped the cycle before
  a_no_empty_start: assert property (@(posedge tag_clk) disable iff (!rst_n)
    tag_en && fk == 4'd0 |-> $past(i_tag_gateway.pop_yumi && i_tag_gateway.pop_valid))
  else
  begin
    $display("a frame started with no packet taken from the FIFO at %0t", $time);
    note_fail(4);
  end

  a_stall: assert property (@(posedge tag_clk) host_check |-> stall_seen)
  else
  begin
    $display("inj_ready_o never dropped during the host burst");
    note_fail(5);
  end
  a_host_regs: assert property (@(posedge tag_clk) host_check |-> clients == host_regs)
    else report_value(5, "clients_r_o", 64'($sampled(clients)), 64'(host_regs));

  a_done_sticky: assert property (@(posedge tag_clk) disable iff (!rst_n) done |=> done)
  else
  begin
    $display("done_o fell before the next reset at %0t", $time);
    note_fail(6);
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic apply_reset();
    @(negedge tag_clk);
    rst_n     = 1'b0;
    en        = 1'b0;
    inj_valid = 1'b0;
    repeat (5) @(negedge tag_clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_done(input int limit, input int which);
    int n;
    n = 0;
    while (!done && n < limit)
    begin
      @(negedge tag_clk);
      n++;
    end
    if (!done)
    begin
      $display("done_o did not rise within %0d cycles", limit);
      errs[which]++;
    end
  endtask

  // Random en_i pauses until the trace completes
  task automatic run_with_pauses(input int limit);
    int n;
    int lo;
    int hi;
    n = 0;
    while (!done && n < limit)
    begin
      lo = take_bits(3);
      hi = 1 + take_bits(3);
      en = 1'b0;
      repeat (lo) @(negedge tag_clk);
      en = 1'b1;
      repeat (hi) @(negedge tag_clk);
      n += lo + hi;
    end
    if (!done)
    begin
      $display("done_o did not rise within %0d cycles with en_i pauses", limit);
      errs[4]++;
    end
  endtask

  task automatic send_burst();
    tag_pkg::tag_packet_t p;
    for (int i = 0; i < HOST_PKTS; i++)
    begin
      p.last    = 1'b0;
      p.client  = tag_pkg::client_id_t'(take_bits(3));
      p.len     = tag_pkg::len_t'(1 + take_bits(3));
      p.payload = tag_pkg::payload_t'(take_bits(8));
      exp_q.push_back(p);
      host_regs[p.client] = masked(p.payload, p.len);
      inj_pkt   = p;
      inj_valid = 1'b1;
      @(negedge tag_clk);
      while (!accepted)
        @(negedge tag_clk);
    end
    inj_valid = 1'b0;
  endtask

  task automatic wait_frames(input int limit);
    int n;
    n = 0;
    while (exp_idx < exp_q.size() && n < limit)
    begin
      @(negedge tag_clk);
      n++;
    end
    if (exp_idx < exp_q.size())
    begin
      $display("only %0d of %0d frames arrived in time", exp_idx, exp_q.size());
      errs[5]++;
    end
  endtask

  task automatic report_test(input int which, input string name);
    if (errs[which] == 0)
      $display("test %0d %s: passed", which, name);
    else
      $display("test %0d %s: %0d errors", which, name, errs[which]);
  endtask

  initial
  begin
    int total;
    int passed;
    lfsr_r     = 16'd16182;
    rst_n      = 1'b0;
    en         = 1'b0;
    inj_valid  = 1'b0;
    inj_pkt    = '0;
    host_check = 1'b0;
    phase      = 1;
    for (int i = 1; i <= 6; i++)
      errs[i] = 0;
    build_model();

    apply_reset();
    @(negedge tag_clk);
    report_test(1, "reset values");

    phase = 2;
    en    = 1'b1;
    wait_done(LIMIT_CYCLES, 2);
    @(negedge tag_clk);
    report_test(2, "trace frames");
    report_test(3, "registers at done");

    phase = 4;
    apply_reset();
    run_with_pauses(LIMIT_CYCLES);
    @(negedge tag_clk);
    report_test(4, "trace with en pauses");

    phase = 5;
    en    = 1'b1;
    send_burst();
    wait_frames(HOST_PKTS * 16 + 64);
    @(negedge tag_clk);
    host_check = 1'b1;
    @(negedge tag_clk);
    host_check = 1'b0;
    report_test(5, "host burst");

    phase = 6;
    repeat (4) @(negedge tag_clk);
    report_test(6, "done stays high");

    total  = 0;
    passed = 0;
    for (int i = 1; i <= 6; i++)
    begin
      total += errs[i];
      if (errs[i] == 0)
        passed++;
    end
    $display("tests 6, passed %0d, failed %0d, errors %0d", passed, 6 - passed, total);
    if (total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", LIMIT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: tag_trace.hex
// One 17-bit trace word per line, op[16:15] client[14:12] len[11:8] payload[7:0]
// op 0 SEND, 1 WAIT, 2 DONE, 3 NOP
008A5
0143C
18000
021FF
08005
03781
0785A
0030F
056C3
08000
04202
018E7
08014
0551F
02800
10000

// File: sim.f
source/tag_pkg.sv
source/tag_trace_rom.sv
source/tag_trace_replay.sv
source/tag_packet_fifo.sv
source/tag_master_serializer.sv
source/tag_master.sv
source/tag_gateway.sv
tests/tb_tag_gateway.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tag gateway testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_tag_gateway -Mdir "$build_dir" -o Vtb_tag_gateway \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_tag_gateway" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" "$log"; then
  exit 0
fi
exit 1
